/* Bender.yml */
package:
  name: cache

sources:
  - logic/cache_pkg.sv
  - logic/cache_ram.sv
  - logic/main_memory.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: test
    files:
      - tb/cache_chk.sv
      - tb/tb_cache.sv

/* build.f */
logic/cache_pkg.sv
logic/cache_ram.sv
logic/main_memory.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/cache_chk.sv
tb/tb_cache.sv

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int mem_latency = 2
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                req,
    input  logic                                                rd,
    input  logic                                                wr,
    input  cache_pkg::addr_t                                    addr,
    input  cache_pkg::word_t                                    wdata,
    output logic                                                ack,
    output logic                                                hit,
    output cache_pkg::word_t                                    rdata,
    output logic                                                tag_we,
    output logic [cache_pkg::index_w-1:0]                       tag_idx,
    output cache_pkg::tag_entry_t                               tag_wentry,
    input  cache_pkg::tag_entry_t                               tag_rentry,
    output logic                                                data_we,
    output logic [cache_pkg::index_w+cache_pkg::word_sel_w-1:0] data_addr,
    output cache_pkg::word_t                                    data_wword,
    input  cache_pkg::word_t                                    data_rword,
    output logic                                                mem_rd,
    output logic                                                mem_wr,
    output cache_pkg::mem_addr_t                                mem_addr,
    output cache_pkg::word_t                                    mem_wdata,
    input  cache_pkg::word_t                                    mem_rdata
);

    localparam int idx_lsb    = cache_pkg::word_sel_w + 1;
    localparam int tag_lsb    = idx_lsb + cache_pkg::index_w;
    localparam int fill_cnt_w = $clog2(mem_latency + cache_pkg::words_per_line + 1);

    typedef enum logic [3:0] {
        st_clear, st_idle, st_wb0, st_wb1, st_wb2, st_wb3,
        st_fill_issue, st_fill_drain, st_cwrite, st_done
    } state_t;

    state_t                            state_q, state_d;
    logic [cache_pkg::index_w-1:0]     clr_idx_q;
    logic [fill_cnt_w-1:0]             fill_cnt_q;  // cycles since the first fill read
    logic [cache_pkg::word_sel_w-1:0]  ret_cnt_q;   // next fill word to come back
    logic                              ack_q;
    logic                              hit_q;
    cache_pkg::word_t                  rdata_q;

    logic [cache_pkg::tag_w-1:0]       req_tag;
    logic [cache_pkg::index_w-1:0]     req_index;
    logic [cache_pkg::word_sel_w-1:0]  req_word;
    logic [cache_pkg::word_sel_w-1:0]  wb_word;
    logic                              access;
    logic                              lookup_hit;
    logic                              in_fill;
    logic                              fill_ret;
    logic                              last_ret;

    assign req_tag    = addr[tag_lsb +: cache_pkg::tag_w];
    assign req_index  = addr[idx_lsb +: cache_pkg::index_w];
    assign req_word   = addr[1 +: cache_pkg::word_sel_w];
    assign access     = req && (rd || wr);
    assign lookup_hit = tag_rentry.valid && (tag_rentry.tag == req_tag);

    assign wb_word  = cache_pkg::word_sel_w'(state_q - st_wb0);  // only meaningful in wb states
    assign in_fill  = (state_q == st_fill_issue) || (state_q == st_fill_drain);
    assign fill_ret = in_fill && (fill_cnt_q >= fill_cnt_w'(mem_latency));
    assign last_ret = fill_ret && (ret_cnt_q == '1);

    // ~~~~~~~~~~~~~~~~~~~~
    // next state and array/memory drive
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d    = state_q;
        tag_we     = 1'b0;
        tag_idx    = req_index;
        tag_wentry = '0;
        data_we    = 1'b0;
        data_addr  = {req_index, req_word};
        data_wword = wdata;
        mem_rd     = 1'b0;
        mem_wr     = 1'b0;
        mem_addr   = {req_tag, req_index, fill_cnt_q[cache_pkg::word_sel_w-1:0]};
        mem_wdata  = data_rword;

        case (state_q)
            st_clear: begin
                tag_we  = 1'b1;  // sweep writes an invalid entry per index
                tag_idx = clr_idx_q;
                if (clr_idx_q == '1) begin
                    state_d = st_idle;
                end
            end

            st_idle: begin
                if (access) begin
                    if (lookup_hit) begin
                        state_d = st_done;
                        if (wr) begin
                            data_we    = 1'b1;
                            tag_we     = 1'b1;
                            tag_wentry = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
                        end
                    end else if (tag_rentry.valid && tag_rentry.dirty) begin
                        state_d = st_wb0;
                    end else begin
                        state_d = st_fill_issue;
                    end
                end
            end

            st_wb0, st_wb1, st_wb2, st_wb3: begin
                mem_wr    = 1'b1;
                data_addr = {req_index, wb_word};
                mem_addr  = {tag_rentry.tag, req_index, wb_word};  // old line address
                state_d   = (state_q == st_wb3) ? st_fill_issue : state_t'(state_q + 4'd1);
            end

            st_fill_issue, st_fill_drain: begin
                if (state_q == st_fill_issue) begin
                    mem_rd = 1'b1;
                    if (fill_cnt_q == fill_cnt_w'(cache_pkg::words_per_line - 1)) begin
                        state_d = st_fill_drain;
                    end
                end
                if (fill_ret) begin
                    data_we    = 1'b1;
                    data_addr  = {req_index, ret_cnt_q};
                    data_wword = mem_rdata;
                end
                if (last_ret) begin
                    tag_we     = 1'b1;  // new line goes in clean
                    tag_wentry = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
                    state_d    = wr ? st_cwrite : st_done;
                end
            end

            st_cwrite: begin
                data_we    = 1'b1;
                tag_we     = 1'b1;
                tag_wentry = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
                state_d    = st_done;
            end

            st_done: begin
                if (!req) begin
                    state_d = st_idle;
                end
            end

            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_clear;
            clr_idx_q  <= '0;
            fill_cnt_q <= '0;
            ret_cnt_q  <= '0;
            ack_q      <= 1'b0;
            hit_q      <= 1'b0;
            rdata_q    <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_clear) begin
                clr_idx_q <= clr_idx_q + 1'b1;
            end
            fill_cnt_q <= in_fill ? fill_cnt_q + 1'b1 : '0;
            if (!in_fill) begin
                ret_cnt_q <= '0;
            end else if (fill_ret) begin
                ret_cnt_q <= ret_cnt_q + 1'b1;
            end
            if (fill_ret && (ret_cnt_q == req_word)) begin
                rdata_q <= mem_rdata;  // requested word on its way into the line
            end
            if ((state_q == st_idle) && access && lookup_hit) begin
                hit_q   <= 1'b1;
                rdata_q <= data_rword;
            end
            if ((state_d == st_done) && (state_q != st_done)) begin
                ack_q <= 1'b1;
            end
            if ((state_q == st_done) && !req) begin
                ack_q <= 1'b0;
                hit_q <= 1'b0;
            end
        end
    end

    assign ack   = ack_q;
    assign hit   = hit_q;
    assign rdata = rdata_q;

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // address fields
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int tag_w          = 5;
    localparam int index_w        = 8;
    localparam int words_per_line = 4;
    localparam int word_sel_w     = $clog2(words_per_line);  // word within a line

    // byte address seen by the processor, bit 0 selects the byte in a word
    typedef logic [tag_w+index_w+word_sel_w:0] addr_t;

    typedef logic [15:0] word_t;

    // word address on the memory side, one bit shorter than addr_t
    typedef logic [tag_w+index_w+word_sel_w-1:0] mem_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // tag array payload
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

endpackage

/* logic/cache_ram.sv */
`timescale 1ns/1ps

module cache_ram #(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [depth];  // plain register array, no reset

    // ~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~

    // a write shows up on the read port the cycle after the edge that stores it
    assign rdata = mem[raddr];

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
    parameter int mem_latency = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic             rd,
    input  logic             wr,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t wdata,
    output logic             ack,
    output logic             hit,
    output cache_pkg::word_t rdata
);

    localparam int lines      = 2 ** cache_pkg::index_w;
    localparam int data_words = lines * cache_pkg::words_per_line;

    logic                              tag_we;
    logic [cache_pkg::index_w-1:0]     tag_idx;
    cache_pkg::tag_entry_t             tag_wentry;
    cache_pkg::tag_entry_t             tag_rentry;
    logic                              data_we;
    logic [$clog2(data_words)-1:0]     data_addr;
    cache_pkg::word_t                  data_wword;
    cache_pkg::word_t                  data_rword;
    logic                              mem_rd;
    logic                              mem_wr;
    cache_pkg::mem_addr_t              mem_addr;
    cache_pkg::word_t                  mem_wdata;
    cache_pkg::word_t                  mem_rdata;

    cache_ctrl #(
        .mem_latency(mem_latency)
    ) ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .hit       (hit),
        .rdata     (rdata),
        .tag_we    (tag_we),
        .tag_idx   (tag_idx),
        .tag_wentry(tag_wentry),
        .tag_rentry(tag_rentry),
        .data_we   (data_we),
        .data_addr (data_addr),
        .data_wword(data_wword),
        .data_rword(data_rword),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    // tag array, one entry per line
    cache_ram #(
        .payload_t(cache_pkg::tag_entry_t),
        .depth    (lines)
    ) tag_ram_i (
        .clk  (clk),
        .we   (tag_we),
        .waddr(tag_idx),
        .wdata(tag_wentry),
        .raddr(tag_idx),
        .rdata(tag_rentry)
    );

    // data array, addressed by index and word
    cache_ram #(
        .payload_t(cache_pkg::word_t),
        .depth    (data_words)
    ) data_ram_i (
        .clk  (clk),
        .we   (data_we),
        .waddr(data_addr),
        .wdata(data_wword),
        .raddr(data_addr),
        .rdata(data_rword)
    );

    main_memory #(
        .mem_latency(mem_latency)
    ) main_memory_i (
        .clk  (clk),
        .rst_n(rst_n),
        .rd   (mem_rd),
        .wr   (mem_wr),
        .addr (mem_addr),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

endmodule

/* logic/main_memory.sv */
`timescale 1ns/1ps

module main_memory #(
    parameter int mem_latency = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rd,
    input  logic                 wr,
    input  cache_pkg::mem_addr_t addr,
    input  cache_pkg::word_t     wdata,
    output cache_pkg::word_t     rdata
);

    localparam int depth = 2 ** $bits(cache_pkg::mem_addr_t);

    cache_pkg::word_t     mem [depth];
    cache_pkg::mem_addr_t addr_q [mem_latency];  // read address line
    logic [mem_latency-1:0] vld_q;               // read valid line

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read pipeline
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        addr_q[0] <= addr;
        for (int i = 1; i < mem_latency; i++) begin
            addr_q[i] <= addr_q[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= rd;
            for (int i = 1; i < mem_latency; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // the last stage holds the read issued mem_latency edges ago
    assign rdata = vld_q[mem_latency-1] ? mem[addr_q[mem_latency-1]] : '0;

endmodule

/* tb/cache_chk.sv */
`timescale 1ns/1ps

module cache_chk (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic mem_rd,
    input logic mem_wr
);

    int unsigned fail_cnt = 0;  // failures seen so far

    // ~~~~~~~~~~~~~~~~~~~~
    // processor handshake
    // ~~~~~~~~~~~~~~~~~~~~

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else begin
        $error("ack rose although req was low");
        fail_cnt++;
    end

    // ack may only fall once the processor has let go of req
    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (req && ack) |=> ack)
    else begin
        $error("ack dropped while req was still high");
        fail_cnt++;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // memory port
    // ~~~~~~~~~~~~~~~~~~~~

    mem_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd && mem_wr))
    else begin
        $error("mem_rd and mem_wr high in the same cycle");
        fail_cnt++;
    end

endmodule

/* tb/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

    localparam int mem_latency  = 2;
    localparam int period_ns    = 100;
    localparam int drive_ns     = 5;
    localparam int wtr_count    = 16;
    localparam int hit_reqs     = 4;
    localparam int evict_rounds = 4;
    localparam int alloc_rounds = 2;
    localparam int mix_count    = 300;
    localparam int n_requests   = 2 * wtr_count + hit_reqs + 3 * evict_rounds
                                  + 7 * alloc_rounds + mix_count;
    localparam int watchdog_ns  = (n_requests * 400 + 300) * period_ns;
    localparam int lines        = 2 ** cache_pkg::index_w;
    localparam int idx_lsb      = cache_pkg::word_sel_w + 1;
    localparam int tag_lsb      = idx_lsb + cache_pkg::index_w;
    localparam int addr_w       = $bits(cache_pkg::addr_t);

    logic             clk;
    logic             rst_n;
    logic             req;
    logic             rd;
    logic             wr;
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
    logic             ack;
    logic             hit;
    cache_pkg::word_t rdata;

    cache_pkg::word_t            mem_model [int];  // written words by word address
    logic                        line_valid [lines];
    logic                        line_dirty [lines];
    logic [cache_pkg::tag_w-1:0] line_tag [lines];

    integer seed = 32'h3571_7e55;
    int     test_checks;
    int     test_errors;
    int     total_checks;
    int     total_errors;
    int     tests_done;
    int     wb_expected;
    int     wb_seen;
    int     chk_fails;

    cache_top #(
        .mem_latency(mem_latency)
    ) cache_top_i (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .rd   (rd),
        .wr   (wr),
        .addr (addr),
        .wdata(wdata),
        .ack  (ack),
        .hit  (hit),
        .rdata(rdata)
    );

    bind cache_top cache_chk chk_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .ack   (ack),
        .mem_rd(mem_rd),
        .mem_wr(mem_wr)
    );

    always #(period_ns / 2) clk = ~clk;

    // a write-back shows as one mem_wr cycle per word of the line
    always @(negedge clk) begin
        if (rst_n && cache_top_i.mem_wr) begin
            wb_seen++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic cache_pkg::addr_t make_addr(input logic [cache_pkg::tag_w-1:0] t,
                                                   input logic [cache_pkg::index_w-1:0] i,
                                                   input logic [cache_pkg::word_sel_w-1:0] w);
        return {t, i, w, 1'b0};
    endfunction

    task automatic note_error();
        test_errors++;
    endtask

    task automatic end_test(input string name);
        $display("test %-20s %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // direct-mapped write-allocate bookkeeping, one call per request
    task automatic model_access(input logic is_wr, input cache_pkg::addr_t a,
                                input cache_pkg::word_t d, output logic exp_hit,
                                output logic known, output cache_pkg::word_t exp_data);
        int                            waddr;
        logic [cache_pkg::index_w-1:0] idx;
        logic [cache_pkg::tag_w-1:0]   tag;
        waddr = int'(a[addr_w-1:1]);
        idx   = a[idx_lsb +: cache_pkg::index_w];
        tag   = a[tag_lsb +: cache_pkg::tag_w];
        exp_hit = line_valid[idx] && (line_tag[idx] == tag);
        if (!exp_hit) begin
            if (line_valid[idx] && line_dirty[idx]) begin
                wb_expected++;  // old line has to go back to memory
            end
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
            line_dirty[idx] = 1'b0;
        end
        if (is_wr) begin
            line_dirty[idx]  = 1'b1;
            mem_model[waddr] = d;
        end
        known    = mem_model.exists(waddr);
        exp_data = known ? mem_model[waddr] : '0;
    endtask

    // one four-phase transfer, entered and left 5 ns after a rising edge
    task automatic do_access(input logic is_wr, input cache_pkg::addr_t a,
                             input cache_pkg::word_t d, output cache_pkg::word_t got_data,
                             output logic got_hit, output int cycles);
        cycles = 0;
        req    = 1'b1;
        rd     = !is_wr;
        wr     = is_wr;
        addr   = a;
        wdata  = d;
        do begin
            @(posedge clk);
            #drive_ns;
            cycles++;
        end while (ack !== 1'b1);
        got_data = rdata;
        got_hit  = hit;
        req = 1'b0;
        rd  = 1'b0;
        wr  = 1'b0;
        do begin
            @(posedge clk);
            #drive_ns;
        end while (ack !== 1'b0);
    endtask

    task automatic run_checked(input logic is_wr, input cache_pkg::addr_t a,
                               input cache_pkg::word_t d);
        cache_pkg::word_t got_data;
        cache_pkg::word_t exp_data;
        logic             got_hit;
        logic             exp_hit;
        logic             known;
        int               cycles;
        model_access(is_wr, a, d, exp_hit, known, exp_data);
        do_access(is_wr, a, d, got_data, got_hit, cycles);
        test_checks++;
        assert (got_hit === exp_hit) else begin
            $display("Error at %0d ns: %s of %h gave hit=%b, expected %b",
                     $time, is_wr ? "write" : "read", a, got_hit, exp_hit);
            note_error();
        end
        if (exp_hit) begin
            test_checks++;
            assert (cycles == 1) else begin
                $display("Error at %0d ns: hit on %h acked after %0d cycles, expected 1",
                         $time, a, cycles);
                note_error();
            end
        end
        if (!is_wr && known) begin  // unwritten memory has no defined value
            test_checks++;
            assert (got_data === exp_data) else begin
                $display("Error at %0d ns: read of %h returned %h, expected %h",
                         $time, a, got_data, exp_data);
                note_error();
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_reset_idle();
        cache_pkg::word_t rdata0;
        rdata0 = rdata;
        repeat (10) begin
            @(posedge clk);
            #drive_ns;
            test_checks++;
            assert (ack === 1'b0 && hit === 1'b0 && rdata === rdata0) else begin
                $display("Error at %0d ns: outputs moved with no request, ack=%b hit=%b rdata=%h",
                         $time, ack, hit, rdata);
                note_error();
            end
        end
    endtask

    task automatic write_then_read();
        cache_pkg::addr_t addrs[$];
        logic [31:0]      r;
        for (int i = 0; i < wtr_count; i++) begin
            r = next_rand();
            run_checked(1'b1, r[addr_w-1:0], r[31:16]);
            addrs.push_back(r[addr_w-1:0]);
        end
        foreach (addrs[i]) begin
            run_checked(1'b0, addrs[i], '0);
        end
    endtask

    task automatic repeat_hits();
        logic [31:0] r;
        r = next_rand();
        run_checked(1'b0, r[addr_w-1:0], '0);
        run_checked(1'b0, r[addr_w-1:0], '0);
        run_checked(1'b1, r[addr_w-1:0], r[31:16]);
        run_checked(1'b0, r[addr_w-1:0], '0);
    endtask

    task automatic dirty_eviction();
        logic [31:0]      r;
        cache_pkg::addr_t a1;
        for (int i = 0; i < evict_rounds; i++) begin
            r  = next_rand();
            a1 = make_addr(r[4:0], r[12:5], r[14:13]);
            run_checked(1'b1, a1, r[31:16]);
            run_checked(1'b0, make_addr(r[4:0] + 5'd1, r[12:5], r[14:13]), '0);
            run_checked(1'b0, a1, '0);  // comes back through memory
        end
    endtask

    task automatic write_miss_allocate();
        logic [31:0]                      r;
        logic [cache_pkg::word_sel_w-1:0] w;
        for (int i = 0; i < alloc_rounds; i++) begin
            r = next_rand();
            w = r[14:13];
            run_checked(1'b1, make_addr(r[4:0], r[12:5], w + 2'd1), r[31:16]);
            run_checked(1'b0, make_addr(r[4:0] + 5'd3, r[12:5], w), '0);
            run_checked(1'b1, make_addr(r[4:0], r[12:5], w), ~r[31:16]);
            for (int k = 0; k < cache_pkg::words_per_line; k++) begin
                run_checked(1'b0, make_addr(r[4:0], r[12:5], k[1:0]), '0);
            end
        end
    endtask

    task automatic random_mix();
        logic [31:0] r;
        for (int i = 0; i < mix_count; i++) begin
            r = next_rand();
            // four tags over eight lines keep the conflicts coming
            run_checked(r[7], make_addr({3'b000, r[1:0]}, {5'b00000, r[4:2]}, r[6:5]),
                        r[31:16]);
        end
    endtask

    // every dirty miss the model predicted must have moved a whole line to memory
    task automatic check_write_backs();
        test_checks++;
        assert (wb_seen == cache_pkg::words_per_line * wb_expected) else begin
            $display("Error at %0d ns: %0d write-back cycles on the memory port, expected %0d",
                     $time, wb_seen, cache_pkg::words_per_line * wb_expected);
            note_error();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        addr         = '0;
        wdata        = '0;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_done   = 0;
        wb_expected  = 0;
        wb_seen      = 0;
        for (int i = 0; i < lines; i++) begin
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
            line_tag[i]   = '0;
        end
        repeat (4) @(posedge clk);
        #drive_ns;
        rst_n = 1'b1;

        check_reset_idle();
        end_test("reset_idle");
        write_then_read();
        end_test("write_then_read");
        repeat_hits();
        end_test("hit_prediction");
        dirty_eviction();
        end_test("dirty_eviction");
        write_miss_allocate();
        end_test("write_miss_allocate");
        random_mix();
        end_test("random_mix");
        check_write_backs();
        end_test("write_back_count");

        chk_fails = cache_top_i.chk_i.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures, %0d write-backs",
                 tests_done, total_checks, total_errors, chk_fails, wb_expected);
        if (total_errors == 0 && chk_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, a request never got its ack", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
